// File: dv/filter7x7_vectors.txt
// 80 pixels of a 10x8 frame, raster order, one row per line (value = row*16 + col)
// then 8 window sums in hex, bottom-right corner at rows 6..7 and cols 6..9
00 01 02 03 04 05 06 07 08 09
10 11 12 13 14 15 16 17 18 19
20 21 22 23 24 25 26 27 28 29
30 31 32 33 34 35 36 37 38 39
40 41 42 43 44 45 46 47 48 49
50 51 52 53 54 55 56 57 58 59
60 61 62 63 64 65 66 67 68 69
70 71 72 73 74 75 76 77 78 79
// sums for row 6
09C3
09F4
0A25
0A56
// sums for row 7
0CD3
0D04
0D35
0D66

// File: dv/tb_filter7x7.sv
`timescale 1ns/1ps
`default_nettype none

module tb_filter7x7;

  localparam int COLS       = 10;
  localparam int ROWS       = 8;
  localparam int EDGE       = win7_pkg::WIN - 1;
  localparam int FRAME_PIX  = COLS * ROWS;
  localparam int SUM_COLS   = COLS - EDGE;
  localparam int N_SUMS     = SUM_COLS * (ROWS - EDGE);
  localparam int N_VEC      = FRAME_PIX + N_SUMS;
  localparam int LATENCY    = 4;
  localparam int CLK_PERIOD = 20;
  localparam int WATCHDOG_CYCLES = 2 * FRAME_PIX * 5 + 200;  // two frames at worst gap

  logic              clk;
  logic              rst_n;
  logic              pix_valid;
  win7_pkg::pixel_t  pix;
  logic              sum_valid;
  win7_pkg::sum_t    sum;
  logic              frame_end;

  logic [15:0] vec_mem [N_VEC];  // pixels followed by expected sums
  int          cycle_cnt;
  int          errors;
  int          sums_seen;
  int          frame_ends_seen;
  logic [31:0] lcg_state;
  bit          mon_on;

  int sum_cycle_q[$];  // negedge cycle where a sum is due
  int sum_exp_q[$];
  int end_cycle_q[$];

  filter7x7_top #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid),
    .pix_i       (pix),
    .sum_valid_o (sum_valid),
    .sum_o       (sum),
    .frame_end_o (frame_end)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (!rst_n) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // vectors must be complete, and each listed sum must match its pixels
  task automatic check_vectors();
    int br;
    int bc;
    int acc;
    for (int i = 0; i < N_VEC; i++) begin
      if (vec_mem[i][15:14] != 2'b00) begin
        errors++;
        $display("vector file dv/filter7x7_vectors.txt is missing or short at entry %0d", i);
        return;
      end
    end
    for (int k = 0; k < N_SUMS; k++) begin
      br  = EDGE + k / SUM_COLS;
      bc  = EDGE + k % SUM_COLS;
      acc = 0;
      for (int r = br - EDGE; r <= br; r++) begin
        for (int c = bc - EDGE; c <= bc; c++) begin
          acc += int'(vec_mem[r * COLS + c][7:0]);
        end
      end
      if (acc != int'(vec_mem[FRAME_PIX + k])) begin
        errors++;
        $display("Error at %0d ns: vector sum %0d is %0d, its pixels add to %0d",
                 $time, k, vec_mem[FRAME_PIX + k], acc);
      end
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    lcg_state = lcg_next(lcg_state);
    pix_valid = 1'b0;
    pix       = lcg_state[31:24];  // junk that must be ignored
  endtask

  task automatic drive_pixel(input int idx);
    int r;
    int c;
    r = idx / COLS;
    c = idx % COLS;
    @(negedge clk);
    pix_valid = 1'b1;
    pix       = vec_mem[idx][7:0];
    if (r >= EDGE && c >= EDGE) begin
      sum_cycle_q.push_back(cycle_cnt + LATENCY);
      sum_exp_q.push_back(int'(vec_mem[FRAME_PIX + (r - EDGE) * SUM_COLS + (c - EDGE)]));
    end
    if (idx == FRAME_PIX - 1) begin
      end_cycle_q.push_back(cycle_cnt + LATENCY);
    end
  endtask

  task automatic send_frame(input bit with_gaps);
    int gap;
    for (int i = 0; i < FRAME_PIX; i++) begin
      drive_pixel(i);
      if (with_gaps) begin
        lcg_state = lcg_next(lcg_state);
        gap       = int'(lcg_state[17:16]);  // 0 to 3 idle cycles
        for (int g = 0; g < gap; g++) begin
          idle_cycle();
        end
      end
    end
  endtask

  task automatic check_outputs();
    bit sum_due;
    bit end_due;
    int exp_sum;
    sum_due = 1'b0;
    end_due = 1'b0;
    exp_sum = 0;
    if (sum_cycle_q.size() > 0) begin
      if (sum_cycle_q[0] == cycle_cnt) begin
        sum_due = 1'b1;
        exp_sum = sum_exp_q[0];
        void'(sum_cycle_q.pop_front());
        void'(sum_exp_q.pop_front());
      end
    end
    if (end_cycle_q.size() > 0) begin
      if (end_cycle_q[0] == cycle_cnt) begin
        end_due = 1'b1;
        void'(end_cycle_q.pop_front());
      end
    end
    if (sum_valid !== sum_due) begin
      errors++;
      $display("Error at %0d ns: sum_valid_o is %b, expected %b", $time, sum_valid, sum_due);
    end
    if (sum_valid === 1'b1 && sum_due) begin
      sums_seen++;
      if (sum !== win7_pkg::sum_t'(exp_sum)) begin
        errors++;
        $display("Error at %0d ns: sum_o is %0d, expected %0d", $time, sum, exp_sum);
      end
    end
    if (frame_end !== end_due) begin
      errors++;
      $display("Error at %0d ns: frame_end_o is %b, expected %b", $time, frame_end, end_due);
    end
    if (frame_end === 1'b1) begin
      frame_ends_seen++;
    end
  endtask

  always @(negedge clk) begin
    if (mon_on) begin
      check_outputs();
    end
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    pix_valid       = 1'b0;
    pix             = '0;
    errors          = 0;
    sums_seen       = 0;
    frame_ends_seen = 0;
    mon_on          = 1'b0;
    lcg_state       = 32'ha53d_eeaf;
    for (int i = 0; i < N_VEC; i++) begin
      vec_mem[i] = 16'hc000 | 16'(i);  // marks entries the file did not fill
    end
    $readmemh("dv/filter7x7_vectors.txt", vec_mem);
    check_vectors();

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n  = 1'b1;
    mon_on = 1'b1;
    repeat (5) idle_cycle();  // outputs stay low with no pixels

    send_frame(1'b0);
    send_frame(1'b1);  // back to back with random gaps
    idle_cycle();
    while (sum_cycle_q.size() > 0 || end_cycle_q.size() > 0) begin
      idle_cycle();
    end
    repeat (8) idle_cycle();  // catch late strobes

    if (sums_seen != 2 * N_SUMS) begin
      errors++;
      $display("expected %0d window sums over two frames but saw %0d", 2 * N_SUMS, sums_seen);
    end
    if (frame_ends_seen != 2) begin
      errors++;
      $display("expected 2 frame end pulses but saw %0d", frame_ends_seen);
    end

    $display("errors: %0d, sums checked: %0d, frame ends: %0d",
             errors, sums_seen, frame_ends_seen);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/filter7x7_top.sv
`timescale 1ns/1ps
`default_nettype none

module filter7x7_top #(
  parameter int COLS = 10,
  parameter int ROWS = 8
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  pix_valid_i,
  input  win7_pkg::pixel_t     pix_i,
  output logic                 sum_valid_o,
  output win7_pkg::sum_t       sum_o,
  output logic                 frame_end_o
);

  logic              col_valid;
  win7_pkg::column_t col;
  logic              col_last;
  logic              win_valid;
  win7_pkg::window_t win;
  logic              win_last;

  line_buffer_7 #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) u_line_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid_i),
    .pix_i       (pix_i),
    .col_valid_o (col_valid),
    .col_o       (col),
    .last_o      (col_last)
  );

  window_7x7 u_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .col_valid_i (col_valid),
    .col_i       (col),
    .last_i      (col_last),
    .win_valid_o (win_valid),
    .win_o       (win),
    .last_o      (win_last)
  );

  window_sum_49 u_sum (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_valid_i (win_valid),
    .win_i       (win),
    .last_i      (win_last),
    .sum_valid_o (sum_valid_o),
    .sum_o       (sum_o),
    .last_o      (frame_end_o)  // lags the last pixel by 4 cycles
  );

endmodule

`default_nettype wire

// File: rtl/line_buffer_7.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer_7 #(
  parameter int COLS = 10,
  parameter int ROWS = 8
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  pix_valid_i,
  input  win7_pkg::pixel_t     pix_i,
  output logic                 col_valid_o,
  output win7_pkg::column_t    col_o,
  output logic                 last_o
);

  localparam int AW    = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int LINES = win7_pkg::WIN - 1;

  localparam win7_pkg::coord_t COL_MAX = win7_pkg::coord_t'(COLS - 1);
  localparam win7_pkg::coord_t ROW_MAX = win7_pkg::coord_t'(ROWS - 1);

  win7_pkg::pixel_t  line_mem [LINES][COLS];  // line 0 is six rows up
  win7_pkg::coord_t  col_cnt;
  win7_pkg::coord_t  row_cnt;
  logic [AW-1:0]     addr;
  logic              col_wrap;
  logic              row_wrap;
  win7_pkg::pixels_t stack;

  assign addr     = col_cnt[AW-1:0];
  assign col_wrap = (col_cnt == COL_MAX);
  assign row_wrap = (row_cnt == ROW_MAX);

  // older rows from the memories, current pixel on top
  always_comb begin
    for (int k = 0; k < LINES; k++) begin
      stack[k] = line_mem[k][addr];
    end
    stack[LINES] = pix_i;
  end

  // each line moves up one row at this column
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      for (int k = 0; k < LINES; k++) begin
        line_mem[k][addr] <= stack[k+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (pix_valid_i) begin
      if (col_wrap) begin
        col_cnt <= '0;
        if (row_wrap) begin
          row_cnt <= '0;  // next frame
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_o <= 1'b0;
      last_o      <= 1'b0;
    end else begin
      col_valid_o <= pix_valid_i;
      last_o      <= pix_valid_i && col_wrap && row_wrap;
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      col_o.pix     <= stack;
      col_o.pos.col <= col_cnt;
      col_o.pos.row <= row_cnt;
    end
  end

endmodule

`default_nettype wire

// File: rtl/win7_pkg.sv
`default_nettype none

package win7_pkg;

  localparam int WIN       = 7;   // window edge
  localparam int PIX_W     = 8;
  localparam int POS_W     = 10;
  localparam int COL_SUM_W = 11;  // 7 * 255 = 1785
  localparam int SUM_W     = 14;  // 49 * 255 = 12495

  typedef logic [PIX_W-1:0] pixel_t;

  typedef logic [POS_W-1:0] coord_t;

  typedef struct packed {
    coord_t col;
    coord_t row;
  } pos_t;

  // one column of the window, index 0 is the oldest row
  typedef pixel_t [WIN-1:0] pixels_t;

  typedef struct packed {
    pixels_t pix;
    pos_t    pos;  // position of the bottom pixel
  } column_t;

  // column 0 oldest, column WIN-1 newest
  typedef pixels_t [WIN-1:0] window_t;

  typedef logic [COL_SUM_W-1:0] col_sum_t;

  typedef logic [SUM_W-1:0] sum_t;

endpackage

`default_nettype wire

// File: rtl/window_7x7.sv
`timescale 1ns/1ps
`default_nettype none

module window_7x7 (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  col_valid_i,
  input  win7_pkg::column_t    col_i,
  input  wire                  last_i,
  output logic                 win_valid_o,
  output win7_pkg::window_t    win_o,
  output logic                 last_o
);

  localparam win7_pkg::coord_t EDGE = win7_pkg::coord_t'(win7_pkg::WIN - 1);

  win7_pkg::window_t win_q;
  logic              col_full;
  logic              row_full;
  logic              win_full;

  // the newest column lies at least six columns and six rows in
  assign col_full = (col_i.pos.col >= EDGE);
  assign row_full = (col_i.pos.row >= EDGE);
  assign win_full = col_valid_i && col_full && row_full;

  // shift register of columns, newest enters at the top index
  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      for (int c = 0; c < win7_pkg::WIN - 1; c++) begin
        win_q[c] <= win_q[c+1];
      end
      win_q[win7_pkg::WIN-1] <= col_i.pix;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o <= 1'b0;
      last_o      <= 1'b0;
    end else begin
      win_valid_o <= win_full;
      last_o      <= col_valid_i && last_i;  // frame end one stage on
    end
  end

  assign win_o = win_q;

endmodule

`default_nettype wire

// File: rtl/window_sum_49.sv
`timescale 1ns/1ps
`default_nettype none

module window_sum_49 (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  win_valid_i,
  input  win7_pkg::window_t    win_i,
  input  wire                  last_i,
  output logic                 sum_valid_o,
  output win7_pkg::sum_t       sum_o,
  output logic                 last_o
);

  win7_pkg::col_sum_t col_sum_d [win7_pkg::WIN];
  win7_pkg::col_sum_t col_sum_q [win7_pkg::WIN];
  win7_pkg::sum_t     total_d;
  win7_pkg::sum_t     sum_q;
  logic               valid_s1;
  logic               last_s1;
  logic               valid_s2;
  logic               last_s2;

  function automatic win7_pkg::col_sum_t col_total(input win7_pkg::pixels_t p);
    win7_pkg::col_sum_t acc;
    acc = '0;
    for (int r = 0; r < win7_pkg::WIN; r++) begin
      acc = acc + win7_pkg::col_sum_t'(p[r]);
    end
    return acc;
  endfunction

  always_comb begin
    for (int c = 0; c < win7_pkg::WIN; c++) begin
      col_sum_d[c] = col_total(win_i[c]);
    end
  end

  // stage one, seven column sums
  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      for (int c = 0; c < win7_pkg::WIN; c++) begin
        col_sum_q[c] <= col_sum_d[c];
      end
    end
  end

  always_comb begin
    total_d = '0;
    for (int c = 0; c < win7_pkg::WIN; c++) begin
      total_d = total_d + win7_pkg::sum_t'(col_sum_q[c]);
    end
  end

  // stage two, window total
  always_ff @(posedge clk) begin
    if (valid_s1) begin
      sum_q <= total_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
      last_s1  <= 1'b0;
      valid_s2 <= 1'b0;
      last_s2  <= 1'b0;
    end else begin
      valid_s1 <= win_valid_i;
      last_s1  <= last_i;
      valid_s2 <= valid_s1;
      last_s2  <= last_s1;
    end
  end

  assign sum_valid_o = valid_s2;
  assign sum_o       = sum_q;
  assign last_o      = last_s2;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the 7x7 filter testbench with verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_filter7x7 \
  -Mdir obj_dir -o tb_filter7x7 > "$LOG" 2>&1 \
  && ./obj_dir/tb_filter7x7 >> "$LOG" 2>&1 \
  || echo "build or simulation stopped early" >> "$LOG"

cat "$LOG"
grep -q "Done: errors found" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" "$LOG" && { echo "PASS"; exit 0; } \
  || { echo "FAIL: no result line in $LOG"; exit 1; }

// File: sim.f
rtl/win7_pkg.sv
rtl/line_buffer_7.sv
rtl/window_7x7.sv
rtl/window_sum_49.sv
rtl/filter7x7_top.sv
dv/tb_filter7x7.sv
